//--- list.f
hw/scan_pkg.sv
hw/index_counter.sv
hw/scan_fsm.sv
hw/sample_store.sv
hw/matrix_scanner.sv
bench/tb_matrix_scanner.sv

//--- Makefile
# Verilator build and run of the matrix scan controller testbench.

VERILATOR ?= verilator
TOP       ?= tb_matrix_scanner
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SIM      := $(BUILD_DIR)/V$(TOP)
PASS_MSG := === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_matrix_scanner.sv
// ####################
// Testbench for matrix_scanner. DAC and ADC models,
// stimulus table, compare tasks and watchdog.
// ####################

`timescale 1ns/1ps
`default_nettype none

module tb_matrix_scanner
  import scan_pkg::*;
();

  localparam int NUM_TESTS       = 5;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * CELLS * 20 + 200;

  // Stimulus code, first expected sample, mid-scan start strobe.
  dac_code_t   stim_tbl   [NUM_TESTS] = '{10'h000, 10'h155, 10'h3FF, 10'h0A7, 10'h155};
  adc_sample_t base_tbl   [NUM_TESTS] = '{12'h000, 12'h554, 12'hFFC, 12'h29C, 12'h554};
  bit          inject_tbl [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

  logic        clk_i      = 1'b0;
  logic        rst_i      = 1'b1;
  logic        start_i    = 1'b0;
  dac_code_t   stim_i     = '0;
  logic        dac_eoc_i  = 1'b0;
  logic        adc_eoc_i  = 1'b0;
  adc_sample_t adc_data_i = '0;
  row_idx_t    rd_row_i   = '0;
  col_idx_t    rd_col_i   = '0;
  logic        dac_start_o;
  dac_code_t   dac_code_o;
  logic        adc_start_o;
  logic        scan_done_o;
  dac_code_t   stim_q_o;
  adc_sample_t rd_data_o;

  int errors       = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  // Converter model state.
  int          dac_left = 0;
  int          adc_left = 0;
  int          adc_n    = 0;
  logic [31:0] rng      = 32'd15324;

  matrix_scanner u_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .start_i     (start_i),
    .stim_i      (stim_i),
    .dac_eoc_i   (dac_eoc_i),
    .adc_eoc_i   (adc_eoc_i),
    .adc_data_i  (adc_data_i),
    .rd_row_i    (rd_row_i),
    .rd_col_i    (rd_col_i),
    .dac_start_o (dac_start_o),
    .dac_code_o  (dac_code_o),
    .adc_start_o (adc_start_o),
    .scan_done_o (scan_done_o),
    .stim_q_o    (stim_q_o),
    .rd_data_o   (rd_data_o)
  );

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // DAC model. Eoc rises 4 cycles after start.
  always @(posedge clk_i) begin
    if (rst_i) begin
      dac_eoc_i <= 1'b0;
      dac_left  <= 0;
    end else if (dac_start_o) begin
      dac_eoc_i <= 1'b0;
      dac_left  <= 4;
    end else if (dac_left != 0) begin
      dac_left <= dac_left - 1;
      if (dac_left == 1) begin
        dac_eoc_i <= 1'b1;
      end
    end
  end

  // ADC model. Sample is code*4 plus starts since scan start.
  always @(posedge clk_i) begin
    if (rst_i) begin
      adc_eoc_i <= 1'b0;
      adc_left  <= 0;
      adc_n     <= 0;
    end else begin
      if (dac_start_o) begin
        adc_n <= 0;
      end
      if (adc_start_o) begin
        rng        <= xorshift32(rng);
        adc_eoc_i  <= 1'b0;
        adc_left   <= 1 + int'(xorshift32(rng) % 32'd6);   // 1 to 6 cycles.
        adc_data_i <= adc_sample_t'({dac_code_o, 2'b00}) + adc_sample_t'(adc_n);
        adc_n      <= adc_n + 1;
      end else if (adc_left != 0) begin
        adc_left <= adc_left - 1;
        if (adc_left == 1) begin
          adc_eoc_i <= 1'b1;
        end
      end
    end
  end

  task automatic check_sample(input string what, input adc_sample_t exp, input adc_sample_t act);
    if (act !== exp) begin
      $display("Error %s: expected %h, actual %h", what, exp, act);
      errors++;
    end
  endtask

  task automatic check_stim(input string what, input dac_code_t exp, input dac_code_t act);
    if (act !== exp) begin
      $display("Error %s: expected %h, actual %h", what, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
      $display("Error %s: expected %0d, actual %0d", what, exp, act);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before, input int cycles);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %-12s ok      (%0d cycles)", name, cycles);
    end else begin
      tests_failed++;
      $display("test %-12s FAILED  (%0d cycles)", name, cycles);
    end
  endtask

  // No scan activity and done held high for n cycles.
  task automatic idle_check(input string name, input int n);
    int done_low;
    int pulses;
    done_low = 0;
    pulses   = 0;
    repeat (n) begin
      @(negedge clk_i);
      if (!scan_done_o) done_low++;
      if (dac_start_o || adc_start_o) pulses++;
    end
    check_count({name, " done_low"}, 0, done_low);
    check_count({name, " start_pulses"}, 0, pulses);
  endtask

  task automatic run_scan(input int t);
    string       name;
    int          errs_before;
    int          cycles;
    int          adc_starts;
    int          dac_starts;
    bit          dac_seen;
    bit          injected;
    bit          done;
    adc_sample_t exp_val;
    name         = $sformatf("scan_%0d", t);
    errs_before  = errors;
    cycles       = 0;
    adc_starts   = 0;
    dac_starts   = 0;
    dac_seen     = 1'b0;
    injected     = 1'b0;
    done         = 1'b0;
    @(posedge clk_i);
    stim_i  <= stim_tbl[t];
    start_i <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
    while (!done) begin
      @(negedge clk_i);
      cycles++;
      if (dac_seen) begin
        check_stim({name, " dac_code"}, stim_tbl[t], dac_code_o);
      end
      if (dac_start_o) begin
        dac_starts++;
        dac_seen = 1'b1;
      end
      if (adc_start_o) adc_starts++;
      if (scan_done_o) done = 1'b1;
      @(posedge clk_i);
      if (inject_tbl[t] && !injected && adc_starts == 3) begin
        start_i  <= 1'b1;   // Ignored mid-scan.
        injected = 1'b1;
      end else begin
        start_i <= 1'b0;
      end
    end
    check_count({name, " adc_starts"}, CELLS, adc_starts);
    check_count({name, " dac_starts"}, 1, dac_starts);
    check_stim({name, " stim_q"}, stim_tbl[t], stim_q_o);
    check_stim({name, " dac_code_end"}, stim_tbl[t], dac_code_o);
    idle_check({name, " idle"}, 6);
    // Row-major readback.
    for (int n = 0; n < CELLS; n++) begin
      @(posedge clk_i);
      rd_row_i <= row_idx_t'(n / COLS);
      rd_col_i <= col_idx_t'(n % COLS);
      @(negedge clk_i);
      exp_val = base_tbl[t] + adc_sample_t'(n);
      check_sample($sformatf("%s cell[%0d][%0d]", name, n / COLS, n % COLS),
                   exp_val, rd_data_o);
    end
    report_test(name, errs_before, cycles);
  endtask

  initial begin
    int errs_before;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    errs_before = errors;
    idle_check("reset_idle", 10);
    report_test("reset_idle", errs_before, 10);
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_scan(t);
    end
    $display("tests %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

endmodule : tb_matrix_scanner

`default_nettype wire

//--- hw/matrix_scanner.sv
// ####################
// Matrix scan controller top. Sequencer, row and
// column counters, sample store and DAC code register.
// ####################

`timescale 1ns/1ps
`default_nettype none

module matrix_scanner
  import scan_pkg::*;
(
  input  wire              clk_i,
  input  wire              rst_i,
  input  wire              start_i,
  input  wire dac_code_t   stim_i,
  input  wire              dac_eoc_i,
  input  wire              adc_eoc_i,
  input  wire adc_sample_t adc_data_i,
  input  wire row_idx_t    rd_row_i,
  input  wire col_idx_t    rd_col_i,
  output logic             dac_start_o,
  output dac_code_t        dac_code_o,
  output logic             adc_start_o,
  output logic             scan_done_o,
  output dac_code_t        stim_q_o,
  output adc_sample_t      rd_data_o
);

  logic      dac_start;
  logic      stim_we;
  logic      cell_we;
  logic      cell_done;
  cnt_op_t   row_op;
  cnt_op_t   col_op;
  row_idx_t  row_idx;
  col_idx_t  col_idx;
  dac_code_t dac_code_q;

  scan_fsm u_fsm (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .start_i     (start_i),
    .dac_eoc_i   (dac_eoc_i),
    .adc_eoc_i   (adc_eoc_i),
    .cell_done_i (cell_done),
    .row_i       (row_idx),
    .col_i       (col_idx),
    .dac_start_o (dac_start),
    .adc_start_o (adc_start_o),
    .stim_we_o   (stim_we),
    .cell_we_o   (cell_we),
    .row_op_o    (row_op),
    .col_op_o    (col_op),
    .scan_done_o (scan_done_o)
  );

  index_counter #(.idx_t(row_idx_t)) u_row_cnt (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .op_i    (row_op),
    .count_o (row_idx)
  );

  index_counter #(.idx_t(col_idx_t)) u_col_cnt (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .op_i    (col_op),
    .count_o (col_idx)
  );

  // Stimulus code held on the DAC pins for the whole scan.
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      dac_code_q <= '0;
    end else if (dac_start) begin
      dac_code_q <= stim_i;
    end
  end

  sample_store u_store (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .stim_we_i   (stim_we),
    .cell_we_i   (cell_we),
    .stim_i      (dac_code_q),
    .row_i       (row_idx),
    .col_i       (col_idx),
    .adc_data_i  (adc_data_i),
    .rd_row_i    (rd_row_i),
    .rd_col_i    (rd_col_i),
    .cell_done_o (cell_done),
    .stim_q_o    (stim_q_o),
    .rd_data_o   (rd_data_o)
  );

  assign dac_start_o = dac_start;
  assign dac_code_o  = dac_code_q;

endmodule : matrix_scanner

`default_nettype wire

//--- hw/sample_store.sv
// ####################
// Stimulus register and row-major cell memory
// with write-done flag and combinational read port.
// ####################

`timescale 1ns/1ps
`default_nettype none

module sample_store
  import scan_pkg::*;
(
  input  wire              clk_i,
  input  wire              rst_i,
  input  wire              stim_we_i,
  input  wire              cell_we_i,
  input  wire dac_code_t   stim_i,
  input  wire row_idx_t    row_i,
  input  wire col_idx_t    col_i,
  input  wire adc_sample_t adc_data_i,
  input  wire row_idx_t    rd_row_i,
  input  wire col_idx_t    rd_col_i,
  output logic             cell_done_o,
  output dac_code_t        stim_q_o,
  output adc_sample_t      rd_data_o
);

  adc_sample_t mem_q [CELLS];
  dac_code_t   stim_q;
  logic        cell_done_q;
  cell_addr_t  wr_addr;
  cell_addr_t  rd_addr;

  // Row times COLS plus column.
  function automatic cell_addr_t cell_addr(input row_idx_t row, input col_idx_t col);
    return cell_addr_t'(row) * cell_addr_t'(COLS) + cell_addr_t'(col);
  endfunction

  assign wr_addr = cell_addr(row_i, col_i);
  assign rd_addr = cell_addr(rd_row_i, rd_col_i);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cell_done_q <= 1'b0;
      stim_q      <= '0;
      for (int i = 0; i < CELLS; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      cell_done_q <= cell_we_i;   // High from the second write cycle.
      if (stim_we_i) begin
        stim_q <= stim_i;
      end
      if (cell_we_i) begin
        mem_q[wr_addr] <= adc_data_i;
      end
    end
  end

  assign cell_done_o = cell_done_q;
  assign stim_q_o    = stim_q;

  // Unused addresses above the grid read as zero.
  assign rd_data_o = (rd_addr < cell_addr_t'(CELLS)) ? mem_q[rd_addr] : '0;

  // Counter indices always land inside the grid.
  a_wr_addr_range: assert property (
    @(posedge clk_i) disable iff (rst_i)
      cell_we_i |-> (wr_addr < cell_addr_t'(CELLS))
  );

endmodule : sample_store

`default_nettype wire

//--- hw/scan_fsm.sv
// ####################
// Scan sequencer FSM. Drives the DAC and ADC strobes,
// the store write enables and the row/column counter ops.
// ####################

`timescale 1ns/1ps
`default_nettype none

module scan_fsm
  import scan_pkg::*;
(
  input  wire            clk_i,
  input  wire            rst_i,
  input  wire            start_i,
  input  wire            dac_eoc_i,
  input  wire            adc_eoc_i,
  input  wire            cell_done_i,
  input  wire row_idx_t  row_i,
  input  wire col_idx_t  col_i,
  output logic           dac_start_o,
  output logic           adc_start_o,
  output logic           stim_we_o,
  output logic           cell_we_o,
  output cnt_op_t        row_op_o,
  output cnt_op_t        col_op_o,
  output logic           scan_done_o
);

  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0,
    ST_DAC_START = 3'd1,
    ST_DAC_WAIT  = 3'd2,
    ST_STIM_WE   = 3'd3,
    ST_ADC_START = 3'd4,
    ST_ADC_WAIT  = 3'd5,
    ST_CELL_WE   = 3'd6,
    ST_ADVANCE   = 3'd7
  } state_t;

  state_t state_q;
  state_t next_state;

  logic col_last;
  logic row_last;

  // End of row and end of grid.
  assign col_last = (col_i == col_idx_t'(COLS - 1));
  assign row_last = (row_i == row_idx_t'(ROWS - 1));

  always_comb begin
    next_state  = state_q;
    dac_start_o = 1'b0;
    adc_start_o = 1'b0;
    stim_we_o   = 1'b0;
    cell_we_o   = 1'b0;
    row_op_o    = CNT_HOLD;
    col_op_o    = CNT_HOLD;
    scan_done_o = 1'b0;

    case (state_q)
      ST_IDLE: begin
        scan_done_o = 1'b1;
        row_op_o    = CNT_CLEAR;   // Counters start each scan at zero.
        col_op_o    = CNT_CLEAR;
        if (start_i) begin
          next_state = ST_DAC_START;
        end
      end

      ST_DAC_START: begin
        dac_start_o = 1'b1;   // Stimulus code loads this cycle.
        next_state  = ST_DAC_WAIT;
      end

      ST_DAC_WAIT: begin
        if (dac_eoc_i) begin
          next_state = ST_STIM_WE;
        end
      end

      ST_STIM_WE: begin
        stim_we_o  = 1'b1;
        next_state = ST_ADC_START;
      end

      ST_ADC_START: begin
        adc_start_o = 1'b1;
        next_state  = ST_ADC_WAIT;
      end

      ST_ADC_WAIT: begin
        if (adc_eoc_i) begin
          next_state = ST_CELL_WE;
        end
      end

      // Store flags done on the second write cycle.
      ST_CELL_WE: begin
        cell_we_o = 1'b1;
        if (cell_done_i) begin
          next_state = ST_ADVANCE;
        end
      end

      ST_ADVANCE: begin
        if (!col_last) begin
          col_op_o   = CNT_INC;
          next_state = ST_ADC_START;
        end else begin
          col_op_o = CNT_CLEAR;
          if (!row_last) begin
            row_op_o   = CNT_INC;
            next_state = ST_ADC_START;
          end else begin
            next_state = ST_IDLE;   // Last cell done.
          end
        end
      end

      default: begin
        next_state = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= next_state;
    end
  end

  // Converter start strobes are single-cycle pulses.
  a_dac_start_pulse: assert property (
    @(posedge clk_i) disable iff (rst_i) dac_start_o |=> !dac_start_o
  );

  a_adc_start_pulse: assert property (
    @(posedge clk_i) disable iff (rst_i) adc_start_o |=> !adc_start_o
  );

  // Stimulus and cell writes never overlap.
  a_we_exclusive: assert property (
    @(posedge clk_i) disable iff (rst_i) !(stim_we_o && cell_we_o)
  );

endmodule : scan_fsm

`default_nettype wire

//--- hw/index_counter.sv
// ####################
// Clear/hold/increment index counter,
// typed for row or column indices.
// ####################

`timescale 1ns/1ps
`default_nettype none

module index_counter
  import scan_pkg::*;
#(
  parameter type idx_t = logic [1:0]
) (
  input  wire          clk_i,
  input  wire          rst_i,
  input  wire cnt_op_t op_i,
  output idx_t         count_o
);

  idx_t count_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      count_q <= idx_t'(0);
    end else begin
      case (op_i)
        CNT_CLEAR: count_q <= idx_t'(0);
        CNT_INC:   count_q <= count_q + idx_t'(1);
        default:   count_q <= count_q;   // Hold.
      endcase
    end
  end

  assign count_o = count_q;

  // Sequencer wraps before the index overflows.
  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (rst_i)
      (op_i == CNT_INC) |-> (count_q != '1)
  );

endmodule : index_counter

`default_nettype wire

//--- hw/scan_pkg.sv
// ####################
// Grid size, converter widths, index types
// and counter operation codes.
// ####################

`default_nettype none

package scan_pkg;

  // Grid of sensing points.
  localparam int ROWS  = 3;
  localparam int COLS  = 3;
  localparam int CELLS = ROWS * COLS;

  // Converter widths.
  localparam int DAC_W = 10;
  localparam int ADC_W = 12;

  typedef logic [1:0] row_idx_t;
  typedef logic [1:0] col_idx_t;
  typedef logic [3:0] cell_addr_t;   // Row-major cell address.

  typedef logic [DAC_W-1:0] dac_code_t;
  typedef logic [ADC_W-1:0] adc_sample_t;

  // Index counter operations.
  typedef enum logic [1:0] {
    CNT_CLEAR = 2'b00,
    CNT_HOLD  = 2'b01,
    CNT_INC   = 2'b10
  } cnt_op_t;

endpackage : scan_pkg

`default_nettype wire
